// ==== all.f ====
+incdir+hdl
hdl/usb_ddr3_pkg.sv
hdl/axis_cmd_parser.sv
hdl/sram_word_port.sv
hdl/axis_resp_framer.sv
hdl/axis_reg_slice.sv
hdl/usb_ddr3_top.sv
tests/usb_ddr3_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f all.f --top-module usb_ddr3_tb -o usb_ddr3_sim
	./obj_dir/usb_ddr3_sim | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/usb_ddr3_tb.sv ====
`include "usb_ddr3_settings.svh"

module usb_ddr3_tb
  import usb_ddr3_pkg::*;
();

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_FRAMES   = 28;  // Command frames plus loopback packets
  localparam int REPLY_CYCLES = 64 + 8 * `MEM_RD_LATENCY;
  localparam int LB_BEATS     = 40;

  logic       clock;
  logic       rst_i;
  logic       s_tvalid_i;
  logic       s_tready_o;
  axis_beat_t s_beat_i;
  logic       m_tvalid_o;
  logic       m_tready_i;
  axis_beat_t m_beat_o;
  logic       lb_in_tvalid_i;
  logic       lb_in_tready_o;
  axis_beat_t lb_in_beat_i;
  logic       lb_out_tvalid_o;
  logic       lb_out_tready_i;
  axis_beat_t lb_out_beat_o;

  integer      seed;
  int          value_errors;
  int          protocol_errors;
  axis_beat_t  reply_q[$];
  logic [15:0] test_addr[4] = '{16'h0000, 16'h0001, 16'h0123, 16'h01FF};
  logic [31:0] written[4];  // Words stored at test_addr

  initial clock = 1'b0;
  always #(CLK_PERIOD / 2) clock = ~clock;

  usb_ddr3_top usb_ddr3_top_inst (
      .clock          (clock),
      .rst_i          (rst_i),
      .s_tvalid_i     (s_tvalid_i),
      .s_tready_o     (s_tready_o),
      .s_beat_i       (s_beat_i),
      .m_tvalid_o     (m_tvalid_o),
      .m_tready_i     (m_tready_i),
      .m_beat_o       (m_beat_o),
      .lb_in_tvalid_i (lb_in_tvalid_i),
      .lb_in_tready_o (lb_in_tready_o),
      .lb_in_beat_i   (lb_in_beat_i),
      .lb_out_tvalid_o(lb_out_tvalid_o),
      .lb_out_tready_i(lb_out_tready_i),
      .lb_out_beat_o  (lb_out_beat_o)
  );

  task automatic check_beat(input string name, input axis_beat_t got, input axis_beat_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAILED at %0t: %s got %h/%b expected %h/%b", $time, name,
               got.tdata, got.tlast, exp.tdata, exp.tlast);
    end
  endtask

  task automatic check_op(input string name, input cmd_op_e got, input cmd_op_e exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Hold one command byte until the parser takes it
  task automatic send_byte(input logic [7:0] data, input logic last);
    logic taken;
    s_tvalid_i     = 1'b1;
    s_beat_i.tdata = data;
    s_beat_i.tlast = last;
    do begin
      @(negedge clock);
      taken = s_tready_o;
      @(posedge clock);
      #10;
    end while (!taken);
    s_tvalid_i = 1'b0;
  endtask

  task automatic send_write(input logic [15:0] addr, input logic [31:0] data);
    send_byte(OP_WRITE, 1'b0);
    send_byte(addr[7:0], 1'b0);
    send_byte(addr[15:8], 1'b0);
    for (int i = 0; i < 4; i++) begin
      send_byte(data[8*i+:8], i == 3);  // LSB first
    end
  endtask

  task automatic send_read(input logic [15:0] addr);
    send_byte(OP_READ, 1'b0);
    send_byte(addr[7:0], 1'b0);
    send_byte(addr[15:8], 1'b1);
  endtask

  // Gather one reply frame, m_tready_i optionally stalled at random
  task automatic collect_reply(input bit stall);
    bit done;
    int cycles;
    reply_q.delete();
    done   = 1'b0;
    cycles = 0;
    while (!done && cycles < REPLY_CYCLES) begin
      m_tready_i = stall ? 1'($random(seed)) : 1'b1;
      @(negedge clock);
      if (m_tvalid_o && m_tready_i) begin
        reply_q.push_back(m_beat_o);
        done = m_beat_o.tlast;
      end
      if (s_tready_o) begin
        protocol_errors++;
        $display("Command stream ready at %0t while a reply is still pending", $time);
      end
      @(posedge clock);
      #10;
      cycles++;
    end
    m_tready_i = 1'b0;
    if (!done) begin
      protocol_errors++;
      $display("No complete reply within %0d cycles at %0t", REPLY_CYCLES, $time);
    end
  endtask

  // Nothing may follow a reply, and the parser must take commands again
  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clock);
      if (m_tvalid_o) begin
        protocol_errors++;
        $display("Unexpected extra reply byte at %0t", $time);
      end
      if (!s_tready_o) begin
        protocol_errors++;
        $display("Command stream still stalled at %0t after the reply", $time);
      end
      @(posedge clock);
      #10;
    end
  endtask

  task automatic expect_ack(input cmd_op_e op);
    axis_beat_t exp;
    exp.tdata = op;
    exp.tlast = 1'b1;
    if (reply_q.size() != 1) begin
      protocol_errors++;
      $display("Expected a one-byte %s reply, got %0d bytes", op.name(), reply_q.size());
    end else begin
      check_beat("m_beat_o", reply_q[0], exp);
    end
    check_idle(4);
  endtask

  task automatic write_and_check(input logic [15:0] addr, input logic [31:0] data);
    send_write(addr, data);
    collect_reply(1'b0);
    expect_ack(OP_WRITE);
  endtask

  task automatic read_and_check(input logic [15:0] addr, input logic [31:0] exp_word,
                                input bit stall);
    axis_beat_t  exp;
    logic [31:0] got_word;
    send_read(addr);
    collect_reply(stall);
    if (reply_q.size() != 5) begin
      protocol_errors++;
      $display("Read of %h gave %0d reply bytes instead of 5", addr, reply_q.size());
    end else begin
      check_op("reply opcode", cmd_op_e'(reply_q[0].tdata), OP_READ);
      for (int i = 0; i < 5; i++) begin
        exp.tdata = (i == 0) ? OP_READ : exp_word[8*(i-1)+:8];
        exp.tlast = (i == 4);
        check_beat("m_beat_o", reply_q[i], exp);
        if (i > 0) got_word[8*(i-1)+:8] = reply_q[i].tdata;
      end
      check_word("read data", got_word, exp_word);
    end
    check_idle(4);
  endtask

  task automatic write_then_read();
    for (int i = 0; i < 4; i++) begin
      written[i] = 32'($random(seed));
      write_and_check(test_addr[i], written[i]);
    end
    for (int i = 0; i < 4; i++) begin
      read_and_check(test_addr[i], written[i], 1'b0);
    end
  endtask

  task automatic address_aliasing();
    logic [31:0] data;
    data = 32'($random(seed));
    write_and_check(16'h0205, data);        // Word 517 wraps to word 5
    read_and_check(16'h0005, data, 1'b0);
    read_and_check(16'hFE05, data, 1'b0);
  endtask

  task automatic bad_frames();
    logic [31:0] keep;
    keep = 32'($random(seed));
    write_and_check(16'h0042, keep);
    // Unknown opcode, closed on byte three
    send_byte(8'h33, 1'b0);
    send_byte(8'h42, 1'b0);
    send_byte(8'h00, 1'b1);
    collect_reply(1'b0);
    expect_ack(OP_ERROR);
    send_byte(OP_READ, 1'b0);  // Read closed early
    send_byte(8'h42, 1'b1);
    collect_reply(1'b0);
    expect_ack(OP_ERROR);
    // Write to the same word that runs past its last data byte
    send_byte(OP_WRITE, 1'b0);
    send_byte(8'h42, 1'b0);
    send_byte(8'h00, 1'b0);
    for (int i = 0; i < 4; i++) begin
      send_byte(~keep[8*i+:8], 1'b0);
    end
    send_byte(8'hA5, 1'b1);
    collect_reply(1'b0);
    expect_ack(OP_ERROR);
    read_and_check(16'h0042, keep, 1'b0);
  endtask

  task automatic reply_backpressure();
    for (int i = 0; i < 4; i++) begin
      read_and_check(test_addr[i], written[i], 1'b1);
    end
  endtask

  task automatic loopback_stream();
    axis_beat_t sent_q[$];
    axis_beat_t got_q[$];
    axis_beat_t beat;
    logic       taken;
    int         cycles;
    for (int i = 0; i < LB_BEATS; i++) begin
      beat.tdata = 8'($random(seed));
      beat.tlast = (i % 5) == 4;  // Five-byte packets
      sent_q.push_back(beat);
    end
    cycles = 0;
    fork
      begin
        foreach (sent_q[i]) begin
          lb_in_tvalid_i = 1'b1;
          lb_in_beat_i   = sent_q[i];
          do begin
            @(negedge clock);
            taken = lb_in_tready_o;
            @(posedge clock);
            #10;
          end while (!taken);
        end
        lb_in_tvalid_i = 1'b0;
      end
      begin
        while (got_q.size() < LB_BEATS && cycles < 10 * LB_BEATS) begin
          lb_out_tready_i = 1'($random(seed));
          @(negedge clock);
          if (lb_out_tvalid_o && lb_out_tready_i) got_q.push_back(lb_out_beat_o);
          @(posedge clock);
          #10;
          cycles++;
        end
      end
    join
    lb_out_tready_i = 1'b1;
    repeat (4) begin
      @(negedge clock);
      if (lb_out_tvalid_o) begin
        protocol_errors++;
        $display("Loopback delivered a beat more than was sent at %0t", $time);
      end
      @(posedge clock);
      #10;
    end
    if (got_q.size() != LB_BEATS) begin
      protocol_errors++;
      $display("Loopback delivered %0d of %0d beats", got_q.size(), LB_BEATS);
    end else begin
      foreach (got_q[i]) check_beat("lb_out_beat_o", got_q[i], sent_q[i]);
    end
  endtask

  initial begin
    #((RESET_CYCLES + 200 * NUM_FRAMES) * CLK_PERIOD);
    $display("Timeout after %0d cycles, the tests did not finish",
             RESET_CYCLES + 200 * NUM_FRAMES);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    seed            = 98;
    value_errors    = 0;
    protocol_errors = 0;
    rst_i           = 1'b1;
    s_tvalid_i      = 1'b0;
    s_beat_i        = '0;
    m_tready_i      = 1'b0;
    lb_in_tvalid_i  = 1'b0;
    lb_in_beat_i    = '0;
    lb_out_tready_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #10;
    rst_i = 1'b0;
    @(negedge clock);
    if (m_tvalid_o || lb_out_tvalid_o || !s_tready_o || !lb_in_tready_o) begin
      protocol_errors++;
      $display("Stream handshakes are not idle after reset");
    end
    @(posedge clock);
    #10;
    write_then_read();
    address_aliasing();
    bad_frames();
    reply_backpressure();
    loopback_stream();
    $display("Errors: %0d wrong values, %0d protocol failures", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule  /* usb_ddr3_tb */

// ==== hdl/usb_ddr3_top.sv ====
module usb_ddr3_top
  import usb_ddr3_pkg::*;
(
    input  logic       clock,
    input  logic       rst_i,

    // Bulk-OUT command stream
    input  logic       s_tvalid_i,
    output logic       s_tready_o,
    input  axis_beat_t s_beat_i,

    // Bulk-IN response stream
    output logic       m_tvalid_o,
    input  logic       m_tready_i,
    output axis_beat_t m_beat_o,

    // Loopback stream pair
    input  logic       lb_in_tvalid_i,
    output logic       lb_in_tready_o,
    input  axis_beat_t lb_in_beat_i,
    output logic       lb_out_tvalid_o,
    input  logic       lb_out_tready_i,
    output axis_beat_t lb_out_beat_o
);

  logic     req_valid;
  mem_req_t req;
  logic     err_valid;
  logic     rsp_valid;
  mem_rsp_t rsp;
  logic     busy;  // Reply still pending

  axis_cmd_parser parser_inst (
      .clock      (clock),
      .rst_i      (rst_i),
      .s_tvalid_i (s_tvalid_i),
      .s_tready_o (s_tready_o),
      .s_beat_i   (s_beat_i),
      .busy_i     (busy),
      .req_valid_o(req_valid),
      .req_o      (req),
      .err_valid_o(err_valid)
  );

  // Stands in for the DDR3 controller and PHY
  sram_word_port sram_inst (
      .clock      (clock),
      .rst_i      (rst_i),
      .req_valid_i(req_valid),
      .req_i      (req),
      .rsp_valid_o(rsp_valid),
      .rsp_o      (rsp)
  );

  axis_resp_framer framer_inst (
      .clock      (clock),
      .rst_i      (rst_i),
      .req_valid_i(req_valid),
      .err_valid_i(err_valid),
      .rsp_valid_i(rsp_valid),
      .rsp_i      (rsp),
      .m_tvalid_o (m_tvalid_o),
      .m_tready_i (m_tready_i),
      .m_beat_o   (m_beat_o),
      .busy_o     (busy)
  );

  axis_reg_slice loopback_inst (
      .clock       (clock),
      .rst_i       (rst_i),
      .in_tvalid_i (lb_in_tvalid_i),
      .in_tready_o (lb_in_tready_o),
      .in_beat_i   (lb_in_beat_i),
      .out_tvalid_o(lb_out_tvalid_o),
      .out_tready_i(lb_out_tready_i),
      .out_beat_o  (lb_out_beat_o)
  );

endmodule  /* usb_ddr3_top */

// ==== hdl/axis_reg_slice.sv ====
module axis_reg_slice
  import usb_ddr3_pkg::*;
(
    input  logic       clock,
    input  logic       rst_i,
    input  logic       in_tvalid_i,
    output logic       in_tready_o,
    input  axis_beat_t in_beat_i,
    output logic       out_tvalid_o,
    input  logic       out_tready_i,
    output axis_beat_t out_beat_o
);

  logic       main_valid_q;
  logic       spare_valid_q;
  axis_beat_t main_beat_q;
  axis_beat_t spare_beat_q;
  logic       main_free;  // Main register empty or emptying this cycle
  logic       in_fire;

  assign in_tready_o  = !spare_valid_q;  // Registered ready
  assign in_fire      = in_tvalid_i && in_tready_o;
  assign main_free    = !main_valid_q || out_tready_i;
  assign out_tvalid_o = main_valid_q;
  assign out_beat_o   = main_beat_q;

  always_ff @(posedge clock) begin
    if (rst_i) begin
      main_valid_q  <= 1'b0;
      spare_valid_q <= 1'b0;
    end else if (main_free) begin
      // Spare drains first, so order is kept
      main_valid_q  <= spare_valid_q || in_tvalid_i;
      spare_valid_q <= 1'b0;
    end else if (in_fire) begin
      spare_valid_q <= 1'b1;  // Output stalled so the beat is parked
    end
  end

  always_ff @(posedge clock) begin
    if (main_free) begin
      main_beat_q <= spare_valid_q ? spare_beat_q : in_beat_i;
    end
    if (in_fire && !main_free) begin
      spare_beat_q <= in_beat_i;
    end
  end

  // Held beat stays put while the consumer stalls
  assert property (@(posedge clock) disable iff (rst_i)
      out_tvalid_o && !out_tready_i |=> out_tvalid_o && $stable(out_beat_o));

endmodule  /* axis_reg_slice */

// ==== hdl/axis_resp_framer.sv ====
module axis_resp_framer
  import usb_ddr3_pkg::*;
(
    input  logic       clock,
    input  logic       rst_i,
    input  logic       req_valid_i,
    input  logic       err_valid_i,
    input  logic       rsp_valid_i,
    input  mem_rsp_t   rsp_i,
    output logic       m_tvalid_o,
    input  logic       m_tready_i,
    output axis_beat_t m_beat_o,
    output logic       busy_o
);

  logic        busy_q;
  logic        tvalid_q;
  logic [2:0]  left_q;   // Bytes still to follow the current one
  logic [39:0] shift_q;  // Reply bytes, next one in the low byte
  logic        m_fire;
  logic        last_beat;

  assign m_fire         = tvalid_q && m_tready_i;
  assign last_beat      = (left_q == 3'd0);
  assign m_tvalid_o     = tvalid_q;
  assign m_beat_o.tdata = shift_q[7:0];
  assign m_beat_o.tlast = last_beat;

  // Busy from the issuing cycle until the reply is gone
  assign busy_o = busy_q || req_valid_i || err_valid_i;

  always_ff @(posedge clock) begin
    if (rst_i) begin
      busy_q   <= 1'b0;
      tvalid_q <= 1'b0;
      left_q   <= 3'd0;
    end else begin
      if (req_valid_i || err_valid_i) begin
        busy_q <= 1'b1;
      end else if (m_fire && last_beat) begin
        busy_q <= 1'b0;
      end

      if (rsp_valid_i) begin
        tvalid_q <= 1'b1;
        left_q   <= (rsp_i.op == OP_READ) ? 3'd4 : 3'd0;  // Write ack is one byte
      end else if (err_valid_i) begin
        tvalid_q <= 1'b1;
        left_q   <= 3'd0;
      end else if (m_fire) begin
        if (last_beat) begin
          tvalid_q <= 1'b0;
        end else begin
          left_q <= left_q - 3'd1;
        end
      end
    end
  end

  // Reply payload, opcode first then data LSB first
  always_ff @(posedge clock) begin
    if (rsp_valid_i) begin
      shift_q <= {rsp_i.rdata, rsp_i.op};
    end else if (err_valid_i) begin
      shift_q <= {32'd0, OP_ERROR};
    end else if (m_fire) begin
      shift_q <= {8'd0, shift_q[39:8]};
    end
  end

  // Held byte stays put under back-pressure
  assert property (@(posedge clock) disable iff (rst_i)
      m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable(m_beat_o));

  // Memory replies only arrive for a tracked command with the output idle
  assert property (@(posedge clock) disable iff (rst_i)
      rsp_valid_i |-> busy_q && !tvalid_q);

endmodule  /* axis_resp_framer */

// ==== hdl/sram_word_port.sv ====
`include "usb_ddr3_settings.svh"

module sram_word_port
  import usb_ddr3_pkg::*;
(
    input  logic     clock,
    input  logic     rst_i,
    input  logic     req_valid_i,
    input  mem_req_t req_i,
    output logic     rsp_valid_o,
    output mem_rsp_t rsp_o
);

  localparam int unsigned WORDS = `SRAM_BYTES / 4;
  localparam int unsigned LAT = `MEM_RD_LATENCY;

  logic    [31:0] mem_array[WORDS];
  logic [LAT-1:0] vld_q;
  cmd_op_e        op_q     [LAT];
  logic    [31:0] data_q   [LAT];

  // Writes land in the request cycle
  always_ff @(posedge clock) begin
    if (req_valid_i && (req_i.op == OP_WRITE)) begin
      mem_array[req_i.addr] <= req_i.wdata;
    end
  end

  // Read data and opcode follow the request down the pipe
  always_ff @(posedge clock) begin
    op_q[0]   <= req_i.op;
    data_q[0] <= mem_array[req_i.addr];
    for (int i = 1; i < LAT; i++) begin
      op_q[i]   <= op_q[i-1];
      data_q[i] <= data_q[i-1];
    end
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= req_valid_i;
      for (int i = 1; i < LAT; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  assign rsp_valid_o = vld_q[LAT-1];
  assign rsp_o.op    = op_q[LAT-1];
  assign rsp_o.rdata = data_q[LAT-1];  // Don't-care for writes

  // The parser only ever issues memory opcodes
  assert property (@(posedge clock) disable iff (rst_i)
      req_valid_i |-> (req_i.op inside {OP_WRITE, OP_READ}));

endmodule  /* sram_word_port */

// ==== hdl/axis_cmd_parser.sv ====
`include "usb_ddr3_settings.svh"

module axis_cmd_parser
  import usb_ddr3_pkg::*;
(
    input  logic       clock,
    input  logic       rst_i,
    input  logic       s_tvalid_i,
    output logic       s_tready_o,
    input  axis_beat_t s_beat_i,
    input  logic       busy_i,
    output logic       req_valid_o,
    output mem_req_t   req_o,
    output logic       err_valid_o
);

  typedef enum logic [2:0] {ST_OP, ST_ADDR, ST_DATA, ST_DRAIN, ST_ISSUE} state_e;

  state_e      state_q;
  logic [1:0]  cnt_q;      // Byte index inside the address or data field
  logic [7:0]  addr_lo_q;
  logic        err_q;
  mem_req_t    req_q;
  logic        s_fire;
  logic        op_ok;
  logic [15:0] addr_full;

  assign s_tready_o  = !busy_i && (state_q != ST_ISSUE);  // One command in flight
  assign s_fire      = s_tvalid_i && s_tready_o;
  assign op_ok       = (s_beat_i.tdata == OP_WRITE) || (s_beat_i.tdata == OP_READ);
  assign addr_full   = {s_beat_i.tdata, addr_lo_q};
  assign req_valid_o = (state_q == ST_ISSUE);
  assign err_valid_o = err_q;
  assign req_o       = req_q;

  // Frame sequencing and length checks
  always_ff @(posedge clock) begin
    if (rst_i) begin
      state_q <= ST_OP;
      cnt_q   <= 2'd0;
      err_q   <= 1'b0;
    end else begin
      err_q <= 1'b0;
      if (state_q == ST_ISSUE) begin
        state_q <= ST_OP;
      end else if (s_fire) begin
        case (state_q)
          ST_OP: begin
            cnt_q <= 2'd0;
            if (s_beat_i.tlast) begin
              err_q <= 1'b1;  // A lone opcode byte is never a frame
            end else if (!op_ok) begin
              state_q <= ST_DRAIN;
            end else begin
              state_q <= ST_ADDR;
            end
          end
          ST_ADDR: begin
            if (cnt_q == 2'd0) begin
              cnt_q <= 2'd1;
              if (s_beat_i.tlast) begin
                err_q   <= 1'b1;
                state_q <= ST_OP;
              end
            end else begin
              cnt_q <= 2'd0;
              if (req_q.op == OP_READ) begin
                state_q <= s_beat_i.tlast ? ST_ISSUE : ST_DRAIN;
              end else if (s_beat_i.tlast) begin
                err_q   <= 1'b1;  // Write frame cut short
                state_q <= ST_OP;
              end else begin
                state_q <= ST_DATA;
              end
            end
          end
          ST_DATA: begin
            cnt_q <= cnt_q + 2'd1;
            if (cnt_q == 2'd3) begin
              state_q <= s_beat_i.tlast ? ST_ISSUE : ST_DRAIN;
            end else if (s_beat_i.tlast) begin
              err_q   <= 1'b1;
              state_q <= ST_OP;
            end
          end
          ST_DRAIN: begin
            // Discard until the host closes the frame
            if (s_beat_i.tlast) begin
              err_q   <= 1'b1;
              state_q <= ST_OP;
            end
          end
          default: state_q <= ST_OP;
        endcase
      end
    end
  end

  // Request assembly
  always_ff @(posedge clock) begin
    if (s_fire) begin
      case (state_q)
        ST_OP: req_q.op <= cmd_op_e'(s_beat_i.tdata);
        ST_ADDR: begin
          if (cnt_q == 2'd0) begin
            addr_lo_q <= s_beat_i.tdata;
          end else begin
            req_q.addr <= addr_full[`MEM_ADDR_BITS-1:0];  // High bits alias
          end
        end
        ST_DATA: req_q.wdata[8*cnt_q+:8] <= s_beat_i.tdata;  // LSB first
        default: ;
      endcase
    end
  end

  // A frame ends in either a request or an error, never both
  assert property (@(posedge clock) disable iff (rst_i) !(req_valid_o && err_valid_o));

endmodule  /* axis_cmd_parser */

// ==== hdl/usb_ddr3_pkg.sv ====
`include "usb_ddr3_settings.svh"

package usb_ddr3_pkg;

  // First byte of every command and reply frame
  typedef enum logic [7:0] {
    OP_WRITE = 8'h57,  // 'W'
    OP_READ  = 8'h52,  // 'R'
    OP_ERROR = 8'h45   // 'E', replies only
  } cmd_op_e;

  // One byte on a bulk endpoint stream
  // Valid and ready are carried as separate wires
  typedef struct packed {
    logic [7:0] tdata;
    logic       tlast;
  } axis_beat_t;

  // Request from the command parser to the word memory
  typedef struct packed {
    cmd_op_e                  op;
    logic [`MEM_ADDR_BITS-1:0] addr;   // Word address
    logic [31:0]              wdata;
  } mem_req_t;

  // Reply from the word memory, one per request
  typedef struct packed {
    cmd_op_e     op;
    logic [31:0] rdata;  // Only meaningful for reads
  } mem_rsp_t;

  // Command frames
  //   write : op, addr lo, addr hi, d0, d1, d2, d3
  //   read  : op, addr lo, addr hi
  // Reply frames
  //   write : op
  //   read  : op, d0, d1, d2, d3
  //   error : OP_ERROR

endpackage

// ==== hdl/usb_ddr3_settings.svh ====
`ifndef USB_DDR3_SETTINGS_SVH
`define USB_DDR3_SETTINGS_SVH

// Size of the on-chip stand-in for the DDR3 array
`define SRAM_BYTES 2048

// Word address width for SRAM_BYTES / 4 words
`define MEM_ADDR_BITS 9

// Request to reply delay in cycles (1 or more)
`define MEM_RD_LATENCY 2

// Frame addresses are 16 bits wide, so anything above
// MEM_ADDR_BITS wraps around the array

`endif
